//--- logic/decode_pkg.sv
package decode_pkg;

    localparam int XLEN         = 32;
    localparam int REG_IDX_BITS = 5;
    localparam int CSR_IDX_BITS = 12;

    // major opcodes, instruction bits 6:2
    localparam logic [4:0] OPC_LOAD     = 5'b00000;
    localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPC_AUIPC    = 5'b00101;
    localparam logic [4:0] OPC_STORE    = 5'b01000;
    localparam logic [4:0] OPC_OP       = 5'b01100;
    localparam logic [4:0] OPC_LUI      = 5'b01101;
    localparam logic [4:0] OPC_BRANCH   = 5'b11000;
    localparam logic [4:0] OPC_JALR     = 5'b11001;
    localparam logic [4:0] OPC_JAL      = 5'b11011;
    localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

    // low bits of a 32-bit encoding
    localparam logic [1:0] OPC_DET      = 2'b11;

    // msb first, so a raw word casts straight onto the fields
    typedef struct packed {
        logic [6:0]              funct7;
        logic [REG_IDX_BITS-1:0] rs2;
        logic [REG_IDX_BITS-1:0] rs1;
        logic [2:0]              funct3;
        logic [REG_IDX_BITS-1:0] rd;
        logic [4:0]              opcode;
        logic [1:0]              op_det;
    } instr_fields_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_fmt_t;

    typedef struct packed {
        logic full;
        logic load;
        logic store;
        logic op_imm;
        logic op_reg;
        logic op_mul;
        logic lui;
        logic auipc;
        logic branch;
        logic jal;
        logic jalr;
        logic system;
        logic csr;
        logic ecall;
        logic ebreak;
        logic mret;
        logic slt_form;
        logic supported;
    } inst_class_t;

    typedef struct packed {
        logic add_override;
        logic op2_inverse;
        logic sh_ar;
        logic group_mux;
        logic div_mux;
    } alu_ctrl_t;

    // one-hot
    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic [CSR_IDX_BITS-1:0] idx;
        logic [REG_IDX_BITS-1:0] imm;
        logic                    write;
        logic                    set;
        logic                    clear;
        logic                    read;
        logic                    ebreak;
    } csr_req_t;

    typedef struct packed {
        logic jal;
        logic jalr;
        logic branch;
        logic store;
        logic mret;
    } flow_t;

endpackage

//--- logic/instr_latch.sv
`timescale 1ns/1ps

module instr_latch
#(
    parameter int PC_BITS = 16
)
(
    input  logic                               i_clk,
    input  logic                               i_reset,
    input  logic                               i_stall,
    input  logic                               i_flush,
    input  logic                               i_ready,
    input  logic [decode_pkg::XLEN-1:0]        i_instruction,
    input  logic [PC_BITS-1:1]                 i_pc,
    input  logic [PC_BITS-1:1]                 i_pc_next,
    output decode_pkg::instr_fields_t          o_fields,
    output logic                               o_valid,
    output logic [PC_BITS-1:1]                 o_pc,
    output logic [PC_BITS-1:1]                 o_pc_next
);

    decode_pkg::instr_fields_t fields;
    logic                      valid;
    logic [PC_BITS-1:1]        pc;
    logic [PC_BITS-1:1]        pc_next;

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            fields <= '0;
            valid  <= 1'b0;
        end
        else if (!i_stall)
        begin
            // empty slot carries an all-zero word
            fields <= i_ready ? decode_pkg::instr_fields_t'(i_instruction) : '0;
            valid  <= i_ready;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            pc      <= i_pc;
            pc_next <= i_pc_next;
        end
    end

    assign o_fields  = fields;
    assign o_valid   = valid;
    assign o_pc      = pc;
    assign o_pc_next = pc_next;

endmodule

//--- logic/opcode_classifier.sv
`timescale 1ns/1ps

module opcode_classifier
(
    input  decode_pkg::instr_fields_t i_fields,
    input  logic                      i_valid,
    output decode_pkg::inst_class_t   o_class,
    output decode_pkg::imm_fmt_t      o_imm_fmt
);

    logic       full;
    logic [4:0] op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic       op_grp;
    logic       sys_trap;
    logic       fence;

    assign op     = i_fields.opcode;
    assign funct3 = i_fields.funct3;
    assign funct7 = i_fields.funct7;
    assign rs2    = i_fields.rs2;
    assign full   = (i_fields.op_det == decode_pkg::OPC_DET);

    // major groups
    assign o_class.full   = full;
    assign o_class.load   = full & (op == decode_pkg::OPC_LOAD);
    assign o_class.store  = full & (op == decode_pkg::OPC_STORE);
    assign o_class.op_imm = full & (op == decode_pkg::OPC_OP_IMM);
    assign o_class.lui    = full & (op == decode_pkg::OPC_LUI);
    assign o_class.auipc  = full & (op == decode_pkg::OPC_AUIPC);
    assign o_class.branch = full & (op == decode_pkg::OPC_BRANCH);
    assign o_class.jal    = full & (op == decode_pkg::OPC_JAL);
    assign o_class.jalr   = full & (op == decode_pkg::OPC_JALR) & (funct3 == 3'b000);
    assign o_class.system = full & (op == decode_pkg::OPC_SYSTEM);

    // funct7[0] selects the M extension
    assign op_grp         = full & (op == decode_pkg::OPC_OP);
    assign o_class.op_reg = op_grp & ~funct7[0];
    assign o_class.op_mul = op_grp & funct7[0];

    // funct3 of zero holds the trap and return group
    assign sys_trap       = o_class.system & (funct3 == 3'b000);
    assign o_class.csr    = o_class.system & (|funct3);
    assign o_class.ecall  = sys_trap & ~funct7[3] & ~rs2[0];
    assign o_class.ebreak = sys_trap & ~funct7[3] & rs2[0];
    assign o_class.mret   = sys_trap & funct7[4] & (rs2[2:1] == 2'b01);

    // slt, sltu and their immediate forms
    assign o_class.slt_form = (o_class.op_imm | o_class.op_reg) & (funct3[2:1] == 2'b01);

    assign fence = full & (op == decode_pkg::OPC_MISC_MEM) & (funct3 == 3'b000);

    // an empty slot never raises an illegal instruction
    assign o_class.supported = ~i_valid
                             | o_class.load   | o_class.store  | o_class.op_imm
                             | o_class.op_reg | o_class.op_mul
                             | o_class.lui    | o_class.auipc
                             | o_class.branch | o_class.jal    | o_class.jalr
                             | o_class.csr    | o_class.ecall  | o_class.ebreak
                             | o_class.mret   | fence;

    always_comb
    begin
        if (o_class.lui || o_class.auipc)
        begin
            o_imm_fmt = decode_pkg::IMM_U;
        end
        else if (o_class.jal)
        begin
            o_imm_fmt = decode_pkg::IMM_J;
        end
        else if (o_class.store)
        begin
            o_imm_fmt = decode_pkg::IMM_S;
        end
        else if (o_class.branch)
        begin
            o_imm_fmt = decode_pkg::IMM_B;
        end
        else
        begin
            o_imm_fmt = decode_pkg::IMM_I;
        end
    end

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
(
    input  decode_pkg::instr_fields_t   i_fields,
    input  decode_pkg::imm_fmt_t        i_imm_fmt,
    output logic [decode_pkg::XLEN-1:0] o_imm
);

    logic [decode_pkg::XLEN-1:0] w;
    logic [decode_pkg::XLEN-1:0] imm_i;
    logic [decode_pkg::XLEN-1:0] imm_s;
    logic [decode_pkg::XLEN-1:0] imm_b;
    logic [decode_pkg::XLEN-1:0] imm_u;
    logic [decode_pkg::XLEN-1:0] imm_j;

    // back to the raw word for bit slicing
    assign w = i_fields;

    assign imm_i = {{21{w[31]}}, w[30:20]};
    assign imm_s = {{21{w[31]}}, w[30:25], w[11:7]};
    assign imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

    always_comb
    begin
        case (i_imm_fmt)
            decode_pkg::IMM_S: o_imm = imm_s;
            decode_pkg::IMM_B: o_imm = imm_b;
            decode_pkg::IMM_U: o_imm = imm_u;
            decode_pkg::IMM_J: o_imm = imm_j;
            default:           o_imm = imm_i;
        endcase
    end

endmodule

//--- logic/ctrl_gen.sv
`timescale 1ns/1ps

module ctrl_gen
(
    input  decode_pkg::instr_fields_t           i_fields,
    input  decode_pkg::inst_class_t             i_class,
    output decode_pkg::alu_ctrl_t               o_alu_ctrl,
    output decode_pkg::res_src_t                o_res_src,
    output logic                                o_reg_write,
    output logic                                o_op1_src,
    output logic                                o_op2_src,
    output logic [decode_pkg::REG_IDX_BITS-1:0] o_rs1,
    output logic [decode_pkg::REG_IDX_BITS-1:0] o_rs2,
    output logic [decode_pkg::REG_IDX_BITS-1:0] o_rd,
    output logic [2:0]                          o_funct3,
    output decode_pkg::csr_req_t                o_csr,
    output decode_pkg::flow_t                   o_flow
);

    logic add_override;
    logic res_mem;
    logic res_pc_next;

    // address and link arithmetic always adds
    assign add_override = i_class.load | i_class.store | i_class.lui
                        | i_class.auipc | i_class.jal | i_class.jalr;

    assign o_alu_ctrl.add_override = add_override;
    // compares subtract, immediates never do
    assign o_alu_ctrl.op2_inverse  = (i_class.branch | i_class.slt_form) ? 1'b1 :
                                     (add_override | i_class.op_imm)     ? 1'b0 :
                                                                           i_fields.funct7[5];
    assign o_alu_ctrl.sh_ar        = i_fields.funct7[5];
    assign o_alu_ctrl.group_mux    = i_class.op_mul;
    assign o_alu_ctrl.div_mux      = i_class.op_mul & i_fields.funct3[2];

    assign res_mem     = i_class.load;
    assign res_pc_next = i_class.jal | i_class.jalr;

    assign o_res_src.memory  = res_mem;
    assign o_res_src.pc_next = res_pc_next;
    assign o_res_src.alu     = ~(res_mem | res_pc_next);

    assign o_op1_src   = i_class.auipc | i_class.jal;
    assign o_op2_src   = ~(i_class.op_reg | i_class.op_mul | i_class.branch);
    assign o_reg_write = i_class.full & ~i_class.store & ~i_class.branch;

    // lui adds its immediate to x0
    assign o_rs1    = i_class.lui ? '0 : i_fields.rs1;
    assign o_rs2    = i_fields.rs2;
    assign o_rd     = i_fields.rd;
    assign o_funct3 = i_fields.funct3;

    assign o_csr.idx    = {i_fields.funct7, i_fields.rs2};
    assign o_csr.imm    = i_fields.rs1;
    assign o_csr.write  = i_class.system & (i_fields.funct3[1:0] == 2'b01);
    assign o_csr.set    = i_class.system & (i_fields.funct3[1:0] == 2'b10);
    assign o_csr.clear  = i_class.system & (i_fields.funct3[1:0] == 2'b11);
    assign o_csr.read   = i_class.csr;
    assign o_csr.ebreak = i_class.ebreak;

    assign o_flow.jal    = i_class.jal;
    assign o_flow.jalr   = i_class.jalr;
    assign o_flow.branch = i_class.branch;
    assign o_flow.store  = i_class.store;
    assign o_flow.mret   = i_class.mret;

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
#(
    parameter int PC_BITS = 16
)
(
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_stall,
    input  logic                                i_flush,
    input  logic                                i_ready,
    input  logic [decode_pkg::XLEN-1:0]         i_instruction,
    input  logic [PC_BITS-1:1]                  i_pc,
    input  logic [PC_BITS-1:1]                  i_pc_next,
    output decode_pkg::alu_ctrl_t               o_alu_ctrl,
    output decode_pkg::res_src_t                o_res_src,
    output logic                                o_reg_write,
    output logic                                o_op1_src,
    output logic                                o_op2_src,
    output logic [decode_pkg::REG_IDX_BITS-1:0] o_rs1,
    output logic [decode_pkg::REG_IDX_BITS-1:0] o_rs2,
    output logic [decode_pkg::REG_IDX_BITS-1:0] o_rd,
    output logic [2:0]                          o_funct3,
    output decode_pkg::csr_req_t                o_csr,
    output decode_pkg::flow_t                   o_flow,
    output logic [decode_pkg::XLEN-1:0]         o_imm,
    output logic [PC_BITS-1:1]                  o_pc,
    output logic [PC_BITS-1:1]                  o_pc_next,
    output logic                                o_inst_supported
);

    decode_pkg::instr_fields_t fields;
    logic                      valid;
    decode_pkg::inst_class_t   inst_class;
    decode_pkg::imm_fmt_t      imm_fmt;

    // the only register stage, everything after it is combinational
    instr_latch #(
        .PC_BITS       (PC_BITS)
    ) u_latch (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_ready       (i_ready),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .o_fields      (fields),
        .o_valid       (valid),
        .o_pc          (o_pc),
        .o_pc_next     (o_pc_next)
    );

    opcode_classifier u_classifier (
        .i_fields  (fields),
        .i_valid   (valid),
        .o_class   (inst_class),
        .o_imm_fmt (imm_fmt)
    );

    imm_gen u_imm (
        .i_fields  (fields),
        .i_imm_fmt (imm_fmt),
        .o_imm     (o_imm)
    );

    ctrl_gen u_ctrl (
        .i_fields    (fields),
        .i_class     (inst_class),
        .o_alu_ctrl  (o_alu_ctrl),
        .o_res_src   (o_res_src),
        .o_reg_write (o_reg_write),
        .o_op1_src   (o_op1_src),
        .o_op2_src   (o_op2_src),
        .o_rs1       (o_rs1),
        .o_rs2       (o_rs2),
        .o_rd        (o_rd),
        .o_funct3    (o_funct3),
        .o_csr       (o_csr),
        .o_flow      (o_flow)
    );

    assign o_inst_supported = inst_class.supported;

endmodule

//--- bench/tb_encode.svh
// 32-bit encoders, op is the major opcode from bits 6:2

function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] op);
    return {f7, rs2, rs1, f3, rd, op, decode_pkg::OPC_DET};
endfunction

function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] op);
    return {imm, rs1, f3, rd, op, decode_pkg::OPC_DET};
endfunction

function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], decode_pkg::OPC_STORE, decode_pkg::OPC_DET};
endfunction

// imm bit 0 is dropped, offsets are even
function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
            decode_pkg::OPC_BRANCH, decode_pkg::OPC_DET};
endfunction

function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
        input logic [4:0] op);
    return {imm, rd, op, decode_pkg::OPC_DET};
endfunction

function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, decode_pkg::OPC_JAL,
            decode_pkg::OPC_DET};
endfunction

// csr address sits in the I immediate
function automatic logic [31:0] csr_word(input logic [11:0] csr, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
    return itype_word(csr, rs1, f3, rd, decode_pkg::OPC_SYSTEM);
endfunction

//--- bench/tb_decoder.sv
`timescale 1ns/1ps

module tb_decoder;

    // a 2-cycle reset and 26 steps of two cycles
    localparam int TEST_CYCLES = 54;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                  i_clk, i_reset, i_stall, i_flush, i_ready;
    logic [31:0]           i_instruction;
    logic [31:0]           o_imm;
    logic [15:1]           i_pc, i_pc_next;
    logic [15:1]           o_pc, o_pc_next;
    logic                  o_reg_write, o_op1_src, o_op2_src, o_inst_supported;
    logic [4:0]            o_rs1, o_rs2, o_rd;
    logic [2:0]            o_funct3;
    decode_pkg::alu_ctrl_t o_alu_ctrl;
    decode_pkg::res_src_t  o_res_src;
    decode_pkg::csr_req_t  o_csr;
    decode_pkg::flow_t     o_flow;
    integer                seed = 69;
    int                    cycles = 0;
    logic [4:0]            rd_r, rs1_r, rs2_r;
    logic [11:0]           imm_r;
    logic [19:0]           hi_r;

    `include "tb_encode.svh"

    instr_decoder dut0 (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    endtask

    task automatic bit_check(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic idx_check(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    task automatic word_check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            report_mismatch(what, got, exp);
    endtask

    task automatic pc_check(input logic [15:1] got, input logic [15:1] exp, input string what);
        if (got !== exp)
            report_mismatch(what, 32'(got), 32'(exp));
    endtask

    // field order add_override, op2_inverse, sh_ar, group_mux, div_mux
    task automatic alu_check(input decode_pkg::alu_ctrl_t got, input decode_pkg::alu_ctrl_t exp,
            input string what);
        if (got !== exp)
            report_mismatch({what, " alu_ctrl"}, 32'(got), 32'(exp));
    endtask

    // memory, pc_next, alu
    task automatic res_check(input decode_pkg::res_src_t got, input decode_pkg::res_src_t exp,
            input string what);
        if (got !== exp)
            report_mismatch({what, " res_src"}, 32'(got), 32'(exp));
    endtask

    // idx, imm, write, set, clear, read, ebreak
    task automatic csr_check(input decode_pkg::csr_req_t got, input decode_pkg::csr_req_t exp,
            input string what);
        if (got !== exp)
            report_mismatch({what, " csr"}, 32'(got), 32'(exp));
    endtask

    // jal, jalr, branch, store, mret
    task automatic flow_check(input decode_pkg::flow_t got, input decode_pkg::flow_t exp,
            input string what);
        if (got !== exp)
            report_mismatch({what, " flow"}, 32'(got), 32'(exp));
    endtask

    task automatic pick_fields();
        logic [31:0] r1;
        logic [31:0] r2;
        r1    = $random(seed);
        r2    = $random(seed);
        rd_r  = r1[4:0];
        rs1_r = r1[9:5];
        rs2_r = r1[14:10];
        imm_r = r1[31:20];
        hi_r  = r2[19:0];
    endtask

    // drives one word and waits to the falling edge after capture
    task automatic apply_instr(input logic [31:0] word);
        @(posedge i_clk);
        i_instruction <= word;
        i_ready       <= 1'b1;
        i_stall       <= 1'b0;
        i_flush       <= 1'b0;
        i_pc          <= i_pc + 15'd2;
        i_pc_next     <= i_pc + 15'd4;
        @(posedge i_clk);
        @(negedge i_clk);
        pc_check(o_pc, i_pc, "pc");
        pc_check(o_pc_next, i_pc_next, "pc_next");
    endtask

    task automatic idle_check(input string what);
        bit_check(o_reg_write, 1'b0, {what, " reg_write"});
        csr_check(o_csr, '0, what);
        flow_check(o_flow, '0, what);
        res_check(o_res_src, 3'b001, what);
        bit_check(o_inst_supported, 1'b1, {what, " supported"});
    endtask

    task automatic arith_case(input string name, input logic [31:0] word, input logic [2:0] f3,
            input logic is_imm, input logic [31:0] exp_imm, input decode_pkg::alu_ctrl_t exp_alu);
        apply_instr(word);
        idx_check(o_rd, rd_r, {name, " rd"});
        idx_check(o_rs1, rs1_r, {name, " rs1"});
        if (!is_imm)
            idx_check(o_rs2, rs2_r, {name, " rs2"});
        idx_check({2'b0, o_funct3}, {2'b0, f3}, {name, " funct3"});
        alu_check(o_alu_ctrl, exp_alu, name);
        bit_check(o_op2_src, is_imm, {name, " op2_src"});
        bit_check(o_reg_write, 1'b1, {name, " reg_write"});
        if (is_imm)
            word_check(o_imm, exp_imm, {name, " imm"});
    endtask

    task automatic ctrl_case(input string name, input logic [31:0] word, input logic [31:0] exp_imm,
            input decode_pkg::res_src_t exp_res, input decode_pkg::flow_t exp_flow,
            input logic exp_rw, input logic exp_op1);
        apply_instr(word);
        word_check(o_imm, exp_imm, {name, " imm"});
        res_check(o_res_src, exp_res, name);
        flow_check(o_flow, exp_flow, name);
        bit_check(o_reg_write, exp_rw, {name, " reg_write"});
        bit_check(o_op1_src, exp_op1, {name, " op1_src"});
    endtask

    task automatic sys_case(input string name, input logic [31:0] word,
            input decode_pkg::csr_req_t exp_csr, input decode_pkg::flow_t exp_flow);
        apply_instr(word);
        csr_check(o_csr, exp_csr, name);
        flow_check(o_flow, exp_flow, name);
        bit_check(o_inst_supported, 1'b1, {name, " supported"});
    endtask

    task automatic reset_test();
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        idle_check("reset");
    endtask

    task automatic arith_test();
        pick_fields();
        arith_case("add", rtype_word(7'h00, rs2_r, rs1_r, 3'b000, rd_r, decode_pkg::OPC_OP),
                   3'b000, 1'b0, '0, 5'b00000);
        arith_case("sub", rtype_word(7'h20, rs2_r, rs1_r, 3'b000, rd_r, decode_pkg::OPC_OP),
                   3'b000, 1'b0, '0, 5'b01100);
        arith_case("slt", rtype_word(7'h00, rs2_r, rs1_r, 3'b010, rd_r, decode_pkg::OPC_OP),
                   3'b010, 1'b0, '0, 5'b01000);
        arith_case("sra", rtype_word(7'h20, rs2_r, rs1_r, 3'b101, rd_r, decode_pkg::OPC_OP),
                   3'b101, 1'b0, '0, 5'b01100);
        // shift amount reuses the rs2 draw
        arith_case("slli", itype_word({7'h00, rs2_r}, rs1_r, 3'b001, rd_r,
                   decode_pkg::OPC_OP_IMM), 3'b001, 1'b1, {27'b0, rs2_r}, 5'b00000);
        arith_case("addi", itype_word(imm_r, rs1_r, 3'b000, rd_r, decode_pkg::OPC_OP_IMM),
                   3'b000, 1'b1, {{20{imm_r[11]}}, imm_r}, {2'b00, imm_r[10], 2'b00});
    endtask

    task automatic jump_mem_test();
        pick_fields();
        // a non-zero rs1 field shows that lui forces x0
        hi_r[3] = 1'b1;
        ctrl_case("lui", utype_word(hi_r, rd_r, decode_pkg::OPC_LUI), {hi_r, 12'b0},
                  3'b001, 5'b00000, 1'b1, 1'b0);
        idx_check(o_rs1, 5'd0, "lui rs1");
        ctrl_case("auipc", utype_word(hi_r, rd_r, decode_pkg::OPC_AUIPC), {hi_r, 12'b0},
                  3'b001, 5'b00000, 1'b1, 1'b1);
        ctrl_case("jal", jtype_word({hi_r, 1'b0}, rd_r), {{11{hi_r[19]}}, hi_r, 1'b0},
                  3'b010, 5'b10000, 1'b1, 1'b1);
        ctrl_case("jalr", itype_word(imm_r, rs1_r, 3'b000, rd_r, decode_pkg::OPC_JALR),
                  {{20{imm_r[11]}}, imm_r}, 3'b010, 5'b01000, 1'b1, 1'b0);
        ctrl_case("lw", itype_word(imm_r, rs1_r, 3'b010, rd_r, decode_pkg::OPC_LOAD),
                  {{20{imm_r[11]}}, imm_r}, 3'b100, 5'b00000, 1'b1, 1'b0);
        ctrl_case("sw", stype_word(imm_r, rs2_r, rs1_r, 3'b010),
                  {{20{imm_r[11]}}, imm_r}, 3'b001, 5'b00010, 1'b0, 1'b0);
        ctrl_case("beq", btype_word({imm_r, 1'b0}, rs2_r, rs1_r, 3'b000),
                  {{19{imm_r[11]}}, imm_r, 1'b0}, 3'b001, 5'b00100, 1'b0, 1'b0);
        bit_check(o_op2_src, 1'b0, "beq op2_src");
    endtask

    task automatic mext_test();
        pick_fields();
        apply_instr(rtype_word(7'h01, rs2_r, rs1_r, 3'b000, rd_r, decode_pkg::OPC_OP));
        alu_check(o_alu_ctrl, 5'b00010, "mul");
        bit_check(o_inst_supported, 1'b1, "mul supported");
        apply_instr(rtype_word(7'h01, rs2_r, rs1_r, 3'b100, rd_r, decode_pkg::OPC_OP));
        alu_check(o_alu_ctrl, 5'b00011, "div");
        bit_check(o_inst_supported, 1'b1, "div supported");
    endtask

    task automatic system_test();
        pick_fields();
        sys_case("csrrw", csr_word(imm_r, rs1_r, 3'b001, rd_r), {imm_r, rs1_r, 5'b10010}, '0);
        sys_case("csrrs", csr_word(imm_r, rs1_r, 3'b010, rd_r), {imm_r, rs1_r, 5'b01010}, '0);
        sys_case("csrrci", csr_word(imm_r, rs1_r, 3'b111, rd_r), {imm_r, rs1_r, 5'b00110}, '0);
        sys_case("ecall", csr_word(12'h000, 5'd0, 3'b000, 5'd0), '0, '0);
        sys_case("ebreak", csr_word(12'h001, 5'd0, 3'b000, 5'd0), {12'h001, 10'b1}, '0);
        sys_case("mret", csr_word(12'h302, 5'd0, 3'b000, 5'd0), {12'h302, 10'b0}, 5'b00001);
    endtask

    task automatic stage_test();
        logic [15:1] held_pc;
        logic [15:1] held_pc_next;
        pick_fields();
        apply_instr(itype_word(imm_r, rs1_r, 3'b000, rd_r, decode_pkg::OPC_OP_IMM));
        held_pc      = i_pc;
        held_pc_next = i_pc_next;
        @(posedge i_clk);
        i_instruction <= utype_word(hi_r, rd_r, decode_pkg::OPC_LUI);
        i_stall       <= 1'b1;
        i_pc          <= i_pc + 15'd2;
        i_pc_next     <= i_pc_next + 15'd2;
        @(posedge i_clk);
        @(negedge i_clk);
        word_check(o_imm, {{20{imm_r[11]}}, imm_r}, "stall imm");
        pc_check(o_pc, held_pc, "stall pc");
        pc_check(o_pc_next, held_pc_next, "stall pc_next");
        @(posedge i_clk);
        i_stall <= 1'b0;
        @(posedge i_clk);
        @(negedge i_clk);
        word_check(o_imm, {hi_r, 12'b0}, "released imm");
        @(posedge i_clk);
        i_flush <= 1'b1;
        @(posedge i_clk);
        @(negedge i_clk);
        idle_check("flush");
        // custom-1 is not a decoded opcode
        apply_instr({20'h0, rd_r, 5'b01010, 2'b11});
        bit_check(o_inst_supported, 1'b0, "unused opcode supported");
    endtask

    initial
    begin
        i_reset       = 1'b1;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        i_pc_next     = '0;
        reset_test();
        arith_test();
        jump_mem_test();
        mext_test();
        system_test();
        stage_test();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- src.f
+incdir+bench
logic/decode_pkg.sv
logic/instr_latch.sv
logic/opcode_classifier.sv
logic/imm_gen.sv
logic/ctrl_gen.sv
logic/instr_decoder.sv
bench/tb_decoder.sv
